/* source/wb2sdr_macros.svh */
`ifndef WB2SDR_MACROS_SVH
`define WB2SDR_MACROS_SVH

// ----------------------------------------------------------
// Bus widths
// ----------------------------------------------------------

// Wishbone and SDRAM data word in bits
`define WB2SDR_DW 32

// Application word address in bits
`define WB2SDR_AW 26

// ----------------------------------------------------------
// Queue depths
// ----------------------------------------------------------

// Commands waiting for the controller
`define WB2SDR_CMD_DEPTH 4

// Write beats waiting for wr_next
`define WB2SDR_WR_DEPTH 8

// Read words waiting for the bus ack
// One read in flight at most, so this stays small
`define WB2SDR_RD_DEPTH 4

`endif

/* source/wb2sdr_pkg.sv */
`default_nettype none

`include "wb2sdr_macros.svh"

package wb2sdr_pkg;

  // ----------------------------------------------------------
  // Bus side vectors
  // ----------------------------------------------------------

  // One data word
  typedef logic [`WB2SDR_DW-1:0] data_t;

  // Word address toward the controller
  typedef logic [`WB2SDR_AW-1:0] addr_t;

  // Byte lanes, one bit per byte of data_t
  // Also used for the active low SDRAM mask
  typedef logic [`WB2SDR_DW/8-1:0] sel_t;

  // ----------------------------------------------------------
  // Queue entries
  // ----------------------------------------------------------

  // Command entry
  // MSB set for a read, same sense as sdr_req_wr_n
  // Low bits carry the word address
  typedef logic [`WB2SDR_AW:0] cmd_t;

  // Write beat entry
  // Upper nibble is the inverted byte select
  // Lower bits are the write data
  typedef logic [`WB2SDR_DW/8+`WB2SDR_DW-1:0] wrdat_t;

endpackage

`default_nettype wire

/* source/fifo_if.sv */
`default_nettype none

// Push/pop bundle between a queue and its two users
interface fifo_if #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
);

  // Write side
  logic             push;
  logic [WIDTH-1:0] push_data;
  logic             full;

  // Read side
  // pop_data is the oldest entry while empty is low
  logic             pop;
  logic [WIDTH-1:0] pop_data;
  logic             empty;

  // ----------------------------------------------------------
  // Views
  // ----------------------------------------------------------

  // Producer
  modport writer (
    output push,
    output push_data,
    input  full
  );

  // Consumer
  modport reader (
    output pop,
    input  pop_data,
    input  empty
  );

  // The queue itself
  modport storage (
    input  push,
    input  push_data,
    output full,
    input  pop,
    output pop_data,
    output empty
  );

endinterface

`default_nettype wire

/* source/sync_fifo.sv */
`default_nettype none

// Single clock queue with show-ahead output
module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input logic     sdram_clk,
  input logic     wb_clk_i,
  fifo_if.storage q
);

  // Pointer and occupancy widths
  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  // Entry storage
  logic [WIDTH-1:0] mem [DEPTH];

  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_push;
  logic          do_pop;

  // Catch a mismatch between this block and the bundle it serves
  if ((q.DEPTH != DEPTH) || ($bits(q.push_data) != WIDTH)) begin : g_cfg_err
    $error("sync_fifo WIDTH/DEPTH differ from the attached fifo_if");
  end

  // Advance with wrap at the last slot
  function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
    if (p == PW'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // ----------------------------------------------------------
  // Qualified push and pop
  // ----------------------------------------------------------

  // Illegal requests are dropped here and flagged below
  assign do_push = q.push & ~q.full;
  assign do_pop  = q.pop & ~q.empty;

  // Payload write
  always_ff @(posedge sdram_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= q.push_data;
    end
  end

  // Pointers and fill level
  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      // Simultaneous push and pop keeps the level
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ----------------------------------------------------------
  // Flags and show-ahead data
  // ----------------------------------------------------------

  assign q.full     = (count == CW'(DEPTH));
  assign q.empty    = (count == '0);
  // Head entry is valid only while not empty
  assign q.pop_data = mem[rd_ptr];

  // Producer must honour full
  a_no_overflow: assert property (
    @(posedge sdram_clk) disable iff (wb_clk_i) q.push |-> !q.full
  ) else $error("%m overflow, push while full");

  // Consumer must honour empty
  a_no_underflow: assert property (
    @(posedge sdram_clk) disable iff (wb_clk_i) q.pop |-> !q.empty
  ) else $error("%m underflow, pop while empty");

endmodule

`default_nettype wire

/* source/wb_slave_ctrl.sv */
`default_nettype none

// Wishbone slave front end for the SDRAM queues
module wb_slave_ctrl (
  input  logic                wb_clk_i,
  input  logic                sdram_clk,
  input  logic                wb_stb_i,
  input  logic                wb_cyc_i,
  input  logic                wb_we_i,
  input  wb2sdr_pkg::addr_t   wb_addr_i,
  input  wb2sdr_pkg::data_t   wb_dat_i,
  input  wb2sdr_pkg::sel_t    wb_sel_i,
  output logic                wb_ack_o,
  output wb2sdr_pkg::data_t   wb_dat_o,
  fifo_if.writer              cmd_q,
  fifo_if.writer              wr_q,
  fifo_if.reader              rd_q
);

  // Bus cycle decode
  logic wb_req;
  logic wr_ack;
  logic rd_ack;
  logic rd_cmd;

  // Read issued and data not yet returned
  logic pending_rd;

  // Queue entries built from the bus
  wb2sdr_pkg::cmd_t   cmd_word;
  wb2sdr_pkg::wrdat_t wr_word;

  assign wb_req = wb_stb_i & wb_cyc_i;

  // ----------------------------------------------------------
  // Ack generation
  // ----------------------------------------------------------

  // Write acks at once when both queues have room
  assign wr_ack = wb_req & wb_we_i & ~cmd_q.full & ~wr_q.full;

  // Read acks only together with returned data
  assign rd_ack = wb_req & ~wb_we_i & ~rd_q.empty;

  assign wb_ack_o = wr_ack | rd_ack;

  // ----------------------------------------------------------
  // Command and write data push
  // ----------------------------------------------------------

  // One read command per bus read
  assign rd_cmd = wb_req & ~wb_we_i & ~cmd_q.full & ~pending_rd;

  // Read flag on top and address below
  assign cmd_word = {~wb_we_i, wb_addr_i};

  // Byte select goes out as an active low mask
  assign wr_word = {~wb_sel_i, wb_dat_i};

  assign cmd_q.push      = wr_ack | rd_cmd;
  assign cmd_q.push_data = cmd_word;

  // Write beat travels with its command
  assign wr_q.push      = wr_ack;
  assign wr_q.push_data = wr_word;

  // ----------------------------------------------------------
  // Read return
  // ----------------------------------------------------------

  // Data shown straight from the queue head
  assign wb_dat_o = rd_q.pop_data;
  assign rd_q.pop = rd_ack;

  // Set on read command and cleared on read ack
  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      pending_rd <= 1'b0;
    end else if (rd_cmd) begin
      pending_rd <= 1'b1;
    end else if (rd_ack) begin
      pending_rd <= 1'b0;
    end
  end

  // A read command leaves a read pending, so the held bus read pushes no second one
  a_single_read: assert property (
    @(posedge sdram_clk) disable iff (wb_clk_i)
    (cmd_q.push && cmd_word[$bits(cmd_word)-1]) |=>
      !(cmd_q.push && cmd_word[$bits(cmd_word)-1])
  ) else $error("%m read command pushed while a read is pending");

  // Controller returns data only for a read we issued
  a_rd_data_owned: assert property (
    @(posedge sdram_clk) disable iff (wb_clk_i)
    !rd_q.empty |-> pending_rd
  ) else $error("%m read data without an outstanding read");

endmodule

`default_nettype wire

/* source/wb2sdr_top.sv */
`default_nettype none

`include "wb2sdr_macros.svh"

// Wishbone to SDRAM controller bridge
module wb2sdr_top (
  input  logic                sdram_clk,
  input  logic                wb_clk_i,
  // Wishbone slave
  input  logic                wb_stb_i,
  input  logic                wb_cyc_i,
  input  logic                wb_we_i,
  input  wb2sdr_pkg::addr_t   wb_addr_i,
  input  wb2sdr_pkg::data_t   wb_dat_i,
  input  wb2sdr_pkg::sel_t    wb_sel_i,
  output logic                wb_ack_o,
  output wb2sdr_pkg::data_t   wb_dat_o,
  // SDRAM controller request side
  output logic                sdr_req_o,
  output wb2sdr_pkg::addr_t   sdr_req_addr_o,
  output logic                sdr_req_wr_n_o,
  input  logic                sdr_req_ack_i,
  // SDRAM write and read data
  input  logic                sdr_wr_next_i,
  output wb2sdr_pkg::sel_t    sdr_wr_en_n_o,
  output wb2sdr_pkg::data_t   sdr_wr_data_o,
  input  logic                sdr_rd_valid_i,
  input  wb2sdr_pkg::data_t   sdr_rd_data_i
);

  // ----------------------------------------------------------
  // Queues
  // ----------------------------------------------------------

  fifo_if #(.WIDTH($bits(wb2sdr_pkg::cmd_t)),   .DEPTH(`WB2SDR_CMD_DEPTH)) cmd_q ();
  fifo_if #(.WIDTH($bits(wb2sdr_pkg::wrdat_t)), .DEPTH(`WB2SDR_WR_DEPTH))  wr_q ();
  fifo_if #(.WIDTH($bits(wb2sdr_pkg::data_t)),  .DEPTH(`WB2SDR_RD_DEPTH))  rd_q ();

  // Queue heads split into fields
  wb2sdr_pkg::cmd_t   cmd_head;
  wb2sdr_pkg::wrdat_t wr_head;

  sync_fifo #(.WIDTH($bits(wb2sdr_pkg::cmd_t)), .DEPTH(`WB2SDR_CMD_DEPTH)) u_cmd_fifo (
    .sdram_clk (sdram_clk),
    .wb_clk_i  (wb_clk_i),
    .q         (cmd_q.storage)
  );

  sync_fifo #(.WIDTH($bits(wb2sdr_pkg::wrdat_t)), .DEPTH(`WB2SDR_WR_DEPTH)) u_wr_fifo (
    .sdram_clk (sdram_clk),
    .wb_clk_i  (wb_clk_i),
    .q         (wr_q.storage)
  );

  sync_fifo #(.WIDTH($bits(wb2sdr_pkg::data_t)), .DEPTH(`WB2SDR_RD_DEPTH)) u_rd_fifo (
    .sdram_clk (sdram_clk),
    .wb_clk_i  (wb_clk_i),
    .q         (rd_q.storage)
  );

  // ----------------------------------------------------------
  // Bus front end
  // ----------------------------------------------------------

  wb_slave_ctrl u_wb_ctrl (
    .wb_clk_i  (wb_clk_i),
    .sdram_clk (sdram_clk),
    .wb_stb_i  (wb_stb_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_we_i   (wb_we_i),
    .wb_addr_i (wb_addr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_sel_i  (wb_sel_i),
    .wb_ack_o  (wb_ack_o),
    .wb_dat_o  (wb_dat_o),
    .cmd_q     (cmd_q.writer),
    .wr_q      (wr_q.writer),
    .rd_q      (rd_q.reader)
  );

  // ----------------------------------------------------------
  // Controller side
  // ----------------------------------------------------------

  // Request held while a command waits, ack takes it
  assign cmd_head                        = cmd_q.pop_data;
  assign sdr_req_o                       = ~cmd_q.empty;
  assign {sdr_req_wr_n_o, sdr_req_addr_o} = cmd_head;
  assign cmd_q.pop                       = sdr_req_ack_i;

  // Write beat consumed on wr_next
  assign wr_head                       = wr_q.pop_data;
  assign {sdr_wr_en_n_o, sdr_wr_data_o} = wr_head;
  assign wr_q.pop                      = sdr_wr_next_i;

  // Returned read words
  assign rd_q.push      = sdr_rd_valid_i;
  assign rd_q.push_data = sdr_rd_data_i;

endmodule

`default_nettype wire

/* testbench/sdr_ctrl_model.sv */
`default_nettype none

// Behavioral SDRAM controller, serves one request at a time
module sdr_ctrl_model (
  input  logic              sdram_clk,
  input  logic              wb_clk_i,
  input  logic              sdr_req_i,
  input  wb2sdr_pkg::addr_t sdr_req_addr_i,
  input  logic              sdr_req_wr_n_i,
  output logic              sdr_req_ack_o,
  output logic              sdr_wr_next_o,
  input  wb2sdr_pkg::sel_t  sdr_wr_en_n_i,
  input  wb2sdr_pkg::data_t sdr_wr_data_i,
  output logic              sdr_rd_valid_o,
  output wb2sdr_pkg::data_t sdr_rd_data_o,
  input  logic [7:0]        stall_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Accepted commands and write beats, in arrival order
  logic [26:0] cmd_log [256];
  logic [35:0] beat_log [256];
  int cmd_cnt;
  int beat_cnt;
  int rd_cnt;

  // Word memory, sparse
  wb2sdr_pkg::data_t mem [wb2sdr_pkg::addr_t];
  integer seed;

  // Untouched words read back as a pattern of their own address
  function automatic wb2sdr_pkg::data_t blank_word(input wb2sdr_pkg::addr_t a);
    return {a[5:0] ^ 6'h2a, a};
  endfunction

  // Random wait of 0..3 cycles plus the stall setting
  task automatic wait_random();
    int n;
    n = ($random(seed) & 3) + int'(stall_i);
    repeat (n) begin
      @(posedge sdram_clk);
      #2;
    end
  endtask

  // ----------------------------------------------------------
  // Request loop
  // ----------------------------------------------------------

  initial begin
    wb2sdr_pkg::addr_t addr;
    wb2sdr_pkg::data_t word;
    logic              rd;
    seed           = 26;
    cmd_cnt        = 0;
    beat_cnt       = 0;
    rd_cnt         = 0;
    sdr_req_ack_o  = 1'b0;
    sdr_wr_next_o  = 1'b0;
    sdr_rd_valid_o = 1'b0;
    sdr_rd_data_o  = '0;
    forever begin
      @(posedge sdram_clk);
      #2;
      if (!wb_clk_i && sdr_req_i) begin
        wait_random();
        // Take the head command, popped at the next edge
        sdr_req_ack_o = 1'b1;
        addr = sdr_req_addr_i;
        rd = sdr_req_wr_n_i;
        cmd_log[cmd_cnt] = {rd, addr};
        cmd_cnt++;
        @(posedge sdram_clk);
        #2;
        sdr_req_ack_o = 1'b0;
        wait_random();
        word = mem.exists(addr) ? mem[addr] : blank_word(addr);
        if (rd) begin
          sdr_rd_valid_o = 1'b1;
          sdr_rd_data_o = word;
          rd_cnt++;
        end else begin
          // Beat is already queued, it was pushed with the command
          sdr_wr_next_o = 1'b1;
          beat_log[beat_cnt] = {sdr_wr_en_n_i, sdr_wr_data_i};
          beat_cnt++;
          for (int b = 0; b < 4; b++) begin
            if (!sdr_wr_en_n_i[b]) begin
              word[8*b +: 8] = sdr_wr_data_i[8*b +: 8];
            end
          end
          mem[addr] = word;
        end
        @(posedge sdram_clk);
        #2;
        sdr_wr_next_o = 1'b0;
        sdr_rd_valid_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_wb2sdr.sv */
`default_nettype none

module tb_wb2sdr;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ACK_TIMEOUT = 2000;

  logic              sdram_clk;
  logic              wb_clk_i;
  logic              wb_stb_i;
  logic              wb_cyc_i;
  logic              wb_we_i;
  wb2sdr_pkg::addr_t wb_addr_i;
  wb2sdr_pkg::data_t wb_dat_i;
  wb2sdr_pkg::sel_t  wb_sel_i;
  logic              wb_ack_o;
  wb2sdr_pkg::data_t wb_dat_o;
  logic              sdr_req;
  wb2sdr_pkg::addr_t sdr_req_addr;
  logic              sdr_req_wr_n;
  logic              sdr_req_ack;
  logic              sdr_wr_next;
  wb2sdr_pkg::sel_t  sdr_wr_en_n;
  wb2sdr_pkg::data_t sdr_wr_data;
  logic              sdr_rd_valid;
  wb2sdr_pkg::data_t sdr_rd_data;
  logic [7:0]        stall;

  // Expected controller traffic in issue order
  logic [26:0]       exp_cmd [$];
  logic [35:0]       exp_beat [$];
  wb2sdr_pkg::data_t shadow [wb2sdr_pkg::addr_t];
  logic [8*16-1:0]   test_name;
  int                n_reads;

  always #20 sdram_clk = ~sdram_clk;

  wb2sdr_top UUT (
    .sdram_clk (sdram_clk), .wb_clk_i (wb_clk_i),
    .wb_stb_i (wb_stb_i), .wb_cyc_i (wb_cyc_i), .wb_we_i (wb_we_i),
    .wb_addr_i (wb_addr_i), .wb_dat_i (wb_dat_i), .wb_sel_i (wb_sel_i),
    .wb_ack_o (wb_ack_o), .wb_dat_o (wb_dat_o),
    .sdr_req_o (sdr_req), .sdr_req_addr_o (sdr_req_addr), .sdr_req_wr_n_o (sdr_req_wr_n),
    .sdr_req_ack_i (sdr_req_ack), .sdr_wr_next_i (sdr_wr_next),
    .sdr_wr_en_n_o (sdr_wr_en_n), .sdr_wr_data_o (sdr_wr_data),
    .sdr_rd_valid_i (sdr_rd_valid), .sdr_rd_data_i (sdr_rd_data)
  );

  sdr_ctrl_model u_ctrl_model (
    .sdram_clk (sdram_clk), .wb_clk_i (wb_clk_i),
    .sdr_req_i (sdr_req), .sdr_req_addr_i (sdr_req_addr), .sdr_req_wr_n_i (sdr_req_wr_n),
    .sdr_req_ack_o (sdr_req_ack), .sdr_wr_next_o (sdr_wr_next),
    .sdr_wr_en_n_i (sdr_wr_en_n), .sdr_wr_data_i (sdr_wr_data),
    .sdr_rd_valid_o (sdr_rd_valid), .sdr_rd_data_o (sdr_rd_data), .stall_i (stall)
  );

  // ----------------------------------------------------------
  // Reporting and reference model
  // ----------------------------------------------------------

  task automatic abort_run(input string why);
    $display("%0s", why);
    $display("** FAIL **");
    $fatal(1, "%0s", why);
  endtask

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("ERROR %0s %0s: expected %0h, actual %0h", test_name, what, exp, act);
      abort_run("Value mismatch, run stopped");
    end
  endtask

  // Never written words hold a pattern of the full address
  function automatic wb2sdr_pkg::data_t fill_word(input wb2sdr_pkg::addr_t a);
    return {a[5:0] ^ 6'h2a, a};
  endfunction

  function automatic wb2sdr_pkg::data_t shadow_read(input wb2sdr_pkg::addr_t a);
    return shadow.exists(a) ? shadow[a] : fill_word(a);
  endfunction

  // Only selected byte lanes change
  function automatic wb2sdr_pkg::data_t merge_bytes(input wb2sdr_pkg::data_t old,
      input wb2sdr_pkg::data_t nw, input wb2sdr_pkg::sel_t sel);
    wb2sdr_pkg::data_t r;
    r = old;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        r[8*b +: 8] = nw[8*b +: 8];
      end
    end
    return r;
  endfunction

  // ----------------------------------------------------------
  // Bus master
  // ----------------------------------------------------------

  // Called 2 ns after a rising edge and returns at the same point
  task automatic bus_op(input logic we, input wb2sdr_pkg::addr_t addr,
      input wb2sdr_pkg::data_t data, input wb2sdr_pkg::sel_t sel,
      output wb2sdr_pkg::data_t rdata);
    int waited;
    wb_stb_i = 1'b1;
    wb_cyc_i = 1'b1;
    wb_we_i = we;
    wb_addr_i = addr;
    wb_dat_i = data;
    wb_sel_i = sel;
    waited = 0;
    // Ack sampled mid cycle
    @(negedge sdram_clk);
    while (!wb_ack_o && waited < ACK_TIMEOUT) begin
      @(negedge sdram_clk);
      waited++;
    end
    if (!wb_ack_o) begin
      abort_run($sformatf("Timeout waiting for wb_ack_o in test %0s", test_name));
    end else begin
      rdata = wb_dat_o;
      @(posedge sdram_clk);
      #2;
    end
  endtask

  task automatic run_op(input logic [7:0] op, input wb2sdr_pkg::addr_t addr,
      input wb2sdr_pkg::data_t data, input wb2sdr_pkg::sel_t sel);
    wb2sdr_pkg::data_t rdata;
    if (op == "W") begin
      bus_op(1'b1, addr, data, sel, rdata);
      shadow[addr] = merge_bytes(shadow_read(addr), data, sel);
      exp_cmd.push_back({1'b0, addr});
      exp_beat.push_back({~sel, data});
    end else if (op == "R") begin
      exp_cmd.push_back({1'b1, addr});
      bus_op(1'b0, addr, data, sel, rdata);
      n_reads++;
      check_value("read data", 64'(shadow_read(addr)), 64'(rdata));
      // Serial controller has finished all earlier traffic by now
      check_value("commands seen", 64'(exp_cmd.size()), 64'(u_ctrl_model.cmd_cnt));
      check_value("write beats seen", 64'(exp_beat.size()), 64'(u_ctrl_model.beat_cnt));
      check_value("rd_valid pulses", 64'(n_reads), 64'(u_ctrl_model.rd_cnt));
    end else begin
      abort_run($sformatf("Unknown opcode in test %0s", test_name));
    end
  endtask

  // Wait for the queues to empty and compare traffic entry by entry
  task automatic drain_check();
    int waited;
    waited = 0;
    while ((u_ctrl_model.cmd_cnt != exp_cmd.size() || u_ctrl_model.beat_cnt != exp_beat.size())
           && waited < ACK_TIMEOUT) begin
      @(negedge sdram_clk);
      waited++;
    end
    test_name = "drain";
    if (u_ctrl_model.cmd_cnt != exp_cmd.size() || u_ctrl_model.beat_cnt != exp_beat.size()) begin
      abort_run("Timeout waiting for the controller to take every command and write beat");
    end else begin
      for (int i = 0; i < exp_cmd.size(); i++) begin
        check_value("command", 64'(exp_cmd[i]), 64'(u_ctrl_model.cmd_log[i]));
      end
      for (int i = 0; i < exp_beat.size(); i++) begin
        check_value("write beat", 64'(exp_beat[i]), 64'(u_ctrl_model.beat_log[i]));
      end
      check_value("sdr_req_o idle", 64'd0, 64'(sdr_req));
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------

  initial begin
    string             line;
    int                fd;
    int                n;
    int                stall_f;
    logic [7:0]        op_f;
    wb2sdr_pkg::addr_t addr_f;
    wb2sdr_pkg::data_t data_f;
    wb2sdr_pkg::sel_t  sel_f;
    sdram_clk = 1'b0;
    wb_clk_i = 1'b1;
    // Read request held through reset gets no ack from an empty read queue
    wb_stb_i = 1'b1;
    wb_cyc_i = 1'b1;
    wb_we_i = 1'b0;
    wb_addr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    stall = '0;
    n_reads = 0;
    test_name = "reset";
    repeat (4) @(posedge sdram_clk);
    #2;
    check_value("wb_ack_o after reset", 64'd0, 64'(wb_ack_o));
    check_value("sdr_req_o after reset", 64'd0, 64'(sdr_req));
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_clk_i = 1'b0;
    fd = $fopen("testbench/wb2sdr_tests.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open testbench/wb2sdr_tests.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        n = $sscanf(line, "%s %s %h %h %h %d", test_name, op_f, addr_f, data_f, sel_f, stall_f);
        // Skip comments and blank lines
        if (line.len() > 0 && line.getc(0) != "#" && n == 6) begin
          stall = stall_f[7:0];
          run_op(op_f, addr_f, data_f, sel_f);
        end
      end
      $fclose(fd);
    end
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    drain_check();
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/wb2sdr_tests.txt */
# name op addr data sel stall (op W write, R read and check; hex addr, data, sel)
# stall adds wait cycles to every controller delay; reads ignore data
wr_single    W 0000010 cafef00d f 0
rd_single    R 0000010 00000000 f 0
wr_full      W 0000020 11223344 f 0
wr_lane0     W 0000020 000000aa 1 0
wr_lane2     W 0000020 00bb0000 4 2
rd_lanes     R 0000020 00000000 f 0
wr_upper     W 0000021 deadbeef c 1
rd_upper     R 0000021 00000000 f 0
rd_blank_hi  R 3ffffff 00000000 f 0
rd_blank_mid R 1234567 00000000 f 1
# Back-to-back writes, then a read of the same word
b2b_w0       W 0000040 01010101 f 0
b2b_w1       W 0000040 02020202 f 0
b2b_w2       W 0000040 03030303 f 0
b2b_w3       W 0000040 04040404 f 0
b2b_w4       W 0000040 05050505 f 0
b2b_rd       R 0000040 00000000 f 0
mix_w0       W 0000100 a0a0a0a0 f 0
mix_w1       W 0000101 b1b1b1b1 f 0
mix_w2       W 0000102 c2c2c2c2 6 0
mix_rd1      R 0000101 00000000 f 0
mix_rd0      R 0000100 00000000 f 0
mix_rd2      R 0000102 00000000 f 0
# Long controller stalls fill the queues
stall_w0     W 0000200 10000000 f 12
stall_w1     W 0000201 10000001 f 12
stall_w2     W 0000202 10000002 f 12
stall_w3     W 0000203 10000003 f 12
stall_w4     W 0000204 10000004 f 12
stall_w5     W 0000205 10000005 f 12
stall_w6     W 0000206 10000006 f 12
stall_w7     W 0000207 10000007 9 12
stall_rd0    R 0000203 00000000 f 12
stall_rd1    R 0000207 00000000 f 12
stall_w8     W 0000200 77000000 8 9
stall_rd2    R 0000200 00000000 f 0
tail_w       W 2aaaaaa 5a5a5a5a f 0
tail_rd      R 2aaaaaa 00000000 f 0

/* project.f */
+incdir+source
source/wb2sdr_pkg.sv
source/fifo_if.sv
source/sync_fifo.sv
source/wb_slave_ctrl.sv
source/wb2sdr_top.sv
testbench/sdr_ctrl_model.sv
testbench/tb_wb2sdr.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the wb2sdr testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f project.f --top-module tb_wb2sdr -o sim_wb2sdr

# Simulator exit status is ignored here, the log decides
./obj_dir/sim_wb2sdr 2>&1 | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failure"
